// ==== design/xw_types_pkg.sv ====
`default_nettype none

package xw_types_pkg;

   localparam int CFG_ADDR_W   = 6;
   localparam int IO_ADDR_W    = 32;
   localparam int PIXEL_ADDR_W = 10;
   localparam int AXI_LEN_W    = 8;
   localparam int N_STAGES     = 4;

   // address multiplier pipeline depth
   localparam int MUL_LAT      = 4;

   // two-level internal address generator settings
   typedef struct packed {
      logic [PIXEL_ADDR_W-1:0] start;
      logic [PIXEL_ADDR_W-1:0] iterations;
      logic [PIXEL_ADDR_W-1:0] period;
      logic [PIXEL_ADDR_W-1:0] shift;
      logic [PIXEL_ADDR_W-1:0] incr;
      logic [PIXEL_ADDR_W-1:0] delay;
   } ag_cfg_t;

   typedef struct packed {
      logic [IO_ADDR_W-1:0]   base;
      logic [IO_ADDR_W/2-1:0] offset;
   } ext_cfg_t;

   // write side settings that travel together through the shadow chain
   typedef struct packed {
      ag_cfg_t              ag;
      logic [AXI_LEN_W-1:0] len;
   } wr_plan_t;

endpackage

`default_nettype wire

// ==== design/xw_regmap_pkg.sv ====
`default_nettype none

package xw_regmap_pkg;

   // read side
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] RD_EXT_ADDR = 0;
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] RD_OFFSET   = 1;
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] RD_LEN      = 2;
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] RD_START    = 3;
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] RD_ITER     = 4;
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] RD_PER      = 5;
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] RD_SHIFT    = 6;
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] RD_INCR     = 7;

   // write side
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] WR_EXT_ADDR = 8;
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] WR_OFFSET   = 9;
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] WR_LEN      = 10;
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] WR_START    = 11;
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] WR_ITER     = 12;
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] WR_PER      = 13;
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] WR_SHIFT    = 14;
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] WR_INCR     = 15;
   localparam logic [xw_types_pkg::CFG_ADDR_W-1:0] WR_DELAY    = 16;

endpackage

`default_nettype wire

// ==== design/cfg_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// live configuration, one writer and several readers
interface cfg_if;

   xw_types_pkg::ag_cfg_t                    rd_ag;
   xw_types_pkg::ag_cfg_t                    wr_ag;
   xw_types_pkg::ext_cfg_t                   rd_ext;
   xw_types_pkg::ext_cfg_t                   wr_ext;
   logic [xw_types_pkg::IO_ADDR_W/2-1:0]     rd_len;
   logic [xw_types_pkg::AXI_LEN_W-1:0]       wr_len;

   modport regs (
      output rd_ag, wr_ag, rd_ext, wr_ext, rd_len, wr_len
   );

   // view for the consumers of the live settings
   modport users (
      input rd_ag, wr_ag, rd_ext, wr_ext, rd_len, wr_len
   );

endinterface

`default_nettype wire

// ==== design/conf_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module conf_regs (
   input wire                                   clk,
   input wire                                   rst,
   input wire                                   clear,
   input wire                                   valid,
   input wire [xw_types_pkg::CFG_ADDR_W-1:0]    addr,
   input wire [xw_types_pkg::IO_ADDR_W-1:0]     wdata,
   input wire                                   wstrb,
   cfg_if.regs                                  cfg
);

   localparam int AW = xw_types_pkg::IO_ADDR_W;
   localparam int PW = xw_types_pkg::PIXEL_ADDR_W;
   localparam int LW = xw_types_pkg::AXI_LEN_W;

   xw_types_pkg::ext_cfg_t rd_ext_q;
   xw_types_pkg::ext_cfg_t wr_ext_q;
   xw_types_pkg::ag_cfg_t  wr_ag_q;
   logic [AW/2-1:0]        rd_len_q;
   logic [LW-1:0]          wr_len_q;
   logic [PW-1:0]          rd_start_q;
   logic [PW-1:0]          rd_iter_q;
   logic [PW-1:0]          rd_per_q;
   logic [PW-1:0]          rd_shift_q;
   logic [PW-1:0]          rd_incr_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_ext_q   <= '0;
         wr_ext_q   <= '0;
         wr_ag_q    <= '0;
         rd_len_q   <= '0;
         wr_len_q   <= '0;
         rd_start_q <= '0;
         rd_iter_q  <= '0;
         rd_per_q   <= '0;
         rd_shift_q <= '0;
         rd_incr_q  <= '0;
      end else if (clear) begin
         rd_ext_q   <= '0;
         wr_ext_q   <= '0;
         wr_ag_q    <= '0;
         rd_len_q   <= '0;
         wr_len_q   <= '0;
         rd_start_q <= '0;
         rd_iter_q  <= '0;
         rd_per_q   <= '0;
         rd_shift_q <= '0;
         rd_incr_q  <= '0;
      end else if (valid && wstrb) begin
         case (addr)
            xw_regmap_pkg::RD_EXT_ADDR: rd_ext_q.base      <= wdata;
            xw_regmap_pkg::RD_OFFSET:   rd_ext_q.offset    <= wdata[AW/2-1:0];
            xw_regmap_pkg::RD_LEN:      rd_len_q           <= wdata[AW/2-1:0];
            xw_regmap_pkg::RD_START:    rd_start_q         <= wdata[PW-1:0];
            xw_regmap_pkg::RD_ITER:     rd_iter_q          <= wdata[PW-1:0];
            xw_regmap_pkg::RD_PER:      rd_per_q           <= wdata[PW-1:0];
            xw_regmap_pkg::RD_SHIFT:    rd_shift_q         <= wdata[PW-1:0];
            xw_regmap_pkg::RD_INCR:     rd_incr_q          <= wdata[PW-1:0];
            xw_regmap_pkg::WR_EXT_ADDR: wr_ext_q.base      <= wdata;
            xw_regmap_pkg::WR_OFFSET:   wr_ext_q.offset    <= wdata[AW/2-1:0];
            xw_regmap_pkg::WR_LEN:      wr_len_q           <= wdata[LW-1:0];
            xw_regmap_pkg::WR_START:    wr_ag_q.start      <= wdata[PW-1:0];
            xw_regmap_pkg::WR_ITER:     wr_ag_q.iterations <= wdata[PW-1:0];
            xw_regmap_pkg::WR_PER:      wr_ag_q.period     <= wdata[PW-1:0];
            xw_regmap_pkg::WR_SHIFT:    wr_ag_q.shift      <= wdata[PW-1:0];
            xw_regmap_pkg::WR_INCR:     wr_ag_q.incr       <= wdata[PW-1:0];
            xw_regmap_pkg::WR_DELAY:    wr_ag_q.delay      <= wdata[PW-1:0];
            default: ;
         endcase
      end
   end

   // read generator starts right away, no delay register on that side
   assign cfg.rd_ag = '{start:      rd_start_q,
                        iterations: rd_iter_q,
                        period:     rd_per_q,
                        shift:      rd_shift_q,
                        incr:       rd_incr_q,
                        delay:      '0};

   assign cfg.wr_ag  = wr_ag_q;
   assign cfg.rd_ext = rd_ext_q;
   assign cfg.wr_ext = wr_ext_q;
   assign cfg.rd_len = rd_len_q;
   assign cfg.wr_len = wr_len_q;

endmodule

`default_nettype wire

// ==== design/conf_shadow.sv ====
`timescale 1ns/100ps
`default_nettype none

module conf_shadow #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 1
) (
   input wire           clk,
   input wire           rst,
   input wire           run,
   input wire payload_t d,
   output payload_t     q
);

   payload_t pipe [DEPTH];

   // one slot per layer in flight, the last slot is the active one
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            pipe[i] <= '0;
         end
      end else if (run) begin
         pipe[0] <= d;
         for (int i = 1; i < DEPTH; i++) begin
            pipe[i] <= pipe[i-1];
         end
      end
   end

   assign q = pipe[DEPTH-1];

endmodule

`default_nettype wire

// ==== design/stage_addr_calc.sv ====
`timescale 1ns/100ps
`default_nettype none

module stage_addr_calc #(
   parameter int N_STAGES = xw_types_pkg::N_STAGES
) (
   input wire                                             clk,
   input wire xw_types_pkg::ext_cfg_t                     ext,
   output logic [N_STAGES-1:0][xw_types_pkg::IO_ADDR_W-1:0] stage_addr
);

   localparam int AW  = xw_types_pkg::IO_ADDR_W;
   localparam int OW  = AW/2;
   localparam int LAT = xw_types_pkg::MUL_LAT;

   // stage 0 sits at the base itself
   assign stage_addr[0] = ext.base;

   for (genvar i = 1; i < N_STAGES; i++) begin : g_stage
      localparam logic [OW-1:0] IDX = OW'(i);

      logic [OW-1:0] off_q;
      logic [AW-1:0] base_q;
      logic [AW-1:0] base_qq;
      logic [AW-1:0] prod_q;
      logic [AW-1:0] sum_q [LAT-2];

      // input register, multiply, add, then output delay up to LAT
      always_ff @(posedge clk) begin
         off_q    <= ext.offset;
         base_q   <= ext.base;
         prod_q   <= AW'(off_q) * AW'(IDX);
         base_qq  <= base_q;
         sum_q[0] <= prod_q + base_qq;
         for (int k = 1; k < LAT-2; k++) begin
            sum_q[k] <= sum_q[k-1];
         end
      end

      assign stage_addr[i] = sum_q[LAT-3];
   end

endmodule

`default_nettype wire

// ==== design/addr_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module addr_gen #(
   parameter int ADDR_W = xw_types_pkg::PIXEL_ADDR_W
) (
   input wire                         clk,
   input wire                         rst,
   input wire                         run,
   input wire xw_types_pkg::ag_cfg_t  cfg,
   output logic [ADDR_W-1:0]          addr,
   output logic                       en,
   output logic                       done
);

   localparam int PW = xw_types_pkg::PIXEL_ADDR_W;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_DELAY,
      ST_RUN
   } state_t;

   state_t                state;
   xw_types_pkg::ag_cfg_t cfg_q;
   logic [PW-1:0]         dly_cnt;
   logic [PW-1:0]         per_cnt;
   logic [PW-1:0]         iter_cnt;
   logic [ADDR_W-1:0]     origin;
   logic                  last_step;
   logic                  last_iter;

   // settings held for the whole layer
   always_ff @(posedge clk) begin
      if (run) begin
         cfg_q <= cfg;
      end
   end

   assign last_step = per_cnt == cfg_q.period - 1'b1;
   assign last_iter = iter_cnt == cfg_q.iterations - 1'b1;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= ST_IDLE;
         dly_cnt  <= '0;
         per_cnt  <= '0;
         iter_cnt <= '0;
         addr     <= '0;
         origin   <= '0;
      end else if (run) begin
         dly_cnt  <= cfg.delay;
         per_cnt  <= '0;
         iter_cnt <= '0;
         addr     <= ADDR_W'(cfg.start);
         origin   <= ADDR_W'(cfg.start);
         if (cfg.iterations == '0 || cfg.period == '0) begin
            state <= ST_IDLE;
         end else if (cfg.delay == '0) begin
            state <= ST_RUN;
         end else begin
            state <= ST_DELAY;
         end
      end else begin
         case (state)
            ST_DELAY: begin
               if (dly_cnt == PW'(1)) begin
                  state <= ST_RUN;
               end else begin
                  dly_cnt <= dly_cnt - 1'b1;
               end
            end
            ST_RUN: begin
               if (last_step) begin
                  per_cnt <= '0;
                  if (last_iter) begin
                     state <= ST_IDLE;
                  end else begin
                     // next iteration restarts from the shifted origin
                     iter_cnt <= iter_cnt + 1'b1;
                     origin   <= origin + ADDR_W'(cfg_q.shift);
                     addr     <= origin + ADDR_W'(cfg_q.shift);
                  end
               end else begin
                  per_cnt <= per_cnt + 1'b1;
                  addr    <= addr + ADDR_W'(cfg_q.incr);
               end
            end
            default: ;
         endcase
      end
   end

   assign en   = state == ST_RUN;
   assign done = state == ST_IDLE;

endmodule

`default_nettype wire

// ==== design/dma_len_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_len_ctrl (
   input wire                                   clk,
   input wire                                   rst,
   input wire                                   run,
   input wire                                   dma_ready,
   input wire [xw_types_pkg::IO_ADDR_W/2-1:0]   rd_len,
   output logic [xw_types_pkg::AXI_LEN_W-1:0]   dma_rd_len
);

   localparam int LW  = xw_types_pkg::IO_ADDR_W/2;
   localparam int AXW = xw_types_pkg::AXI_LEN_W;

   logic [LW-1:0] cnt;
   logic [LW-1:0] reload;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cnt    <= '0;
         reload <= '0;
      end else if (run) begin
         cnt    <= rd_len;
         reload <= rd_len;
      end else if (dma_ready) begin
         // wraps back to the layer length after the last burst
         if (cnt == '0) begin
            cnt <= reload;
         end else begin
            cnt <= cnt - 1'b1;
         end
      end
   end

   // burst length field is narrower than the count
   assign dma_rd_len = |cnt[LW-1:AXW] ? {AXW{1'b1}} : cnt[AXW-1:0];

endmodule

`default_nettype wire

// ==== design/layer_write_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module layer_write_ctrl #(
   parameter int N_STAGES = xw_types_pkg::N_STAGES
) (
   input wire                                               clk,
   input wire                                               rst,
   input wire                                               clear,
   input wire                                               run,
   input wire                                               valid,
   input wire [xw_types_pkg::CFG_ADDR_W-1:0]                addr,
   input wire [xw_types_pkg::IO_ADDR_W-1:0]                 wdata,
   input wire                                               wstrb,
   input wire                                               dma_ready,
   output logic                                             done,
   output logic [xw_types_pkg::PIXEL_ADDR_W-1:0]            rd_addr,
   output logic                                             rd_en,
   output logic [xw_types_pkg::PIXEL_ADDR_W-1:0]            wr_addr,
   output logic                                             wr_en,
   output logic [N_STAGES-1:0][xw_types_pkg::IO_ADDR_W-1:0] rd_stage_addr,
   output logic [N_STAGES-1:0][xw_types_pkg::IO_ADDR_W-1:0] wr_stage_addr,
   output logic [xw_types_pkg::AXI_LEN_W-1:0]               dma_rd_len,
   output logic [xw_types_pkg::AXI_LEN_W-1:0]               dma_wr_len
);

   typedef logic [N_STAGES-1:0][xw_types_pkg::IO_ADDR_W-1:0] stage_vec_t;

   stage_vec_t               rd_stage_live;
   stage_vec_t               wr_stage_live;
   xw_types_pkg::ag_cfg_t    rd_ag_q;
   xw_types_pkg::wr_plan_t   wr_plan_live;
   xw_types_pkg::wr_plan_t   wr_plan_q;
   logic                     run_d;
   logic                     rd_done;
   logic                     wr_done;

   cfg_if cfg_bus ();

   conf_regs regs_i (
      .clk   (clk),
      .rst   (rst),
      .clear (clear),
      .valid (valid),
      .addr  (addr),
      .wdata (wdata),
      .wstrb (wstrb),
      .cfg   (cfg_bus)
   );

   stage_addr_calc #(.N_STAGES(N_STAGES)) rd_calc_i (
      .clk        (clk),
      .ext        (cfg_bus.rd_ext),
      .stage_addr (rd_stage_live)
   );

   stage_addr_calc #(.N_STAGES(N_STAGES)) wr_calc_i (
      .clk        (clk),
      .ext        (cfg_bus.wr_ext),
      .stage_addr (wr_stage_live)
   );

   assign wr_plan_live = '{ag: cfg_bus.wr_ag, len: cfg_bus.wr_len};

   // the write side trails the read side by one more layer
   conf_shadow #(.payload_t(xw_types_pkg::ag_cfg_t), .DEPTH(2)) rd_ag_sh_i (
      .clk (clk),
      .rst (rst),
      .run (run),
      .d   (cfg_bus.rd_ag),
      .q   (rd_ag_q)
   );

   conf_shadow #(.payload_t(xw_types_pkg::wr_plan_t), .DEPTH(3)) wr_plan_sh_i (
      .clk (clk),
      .rst (rst),
      .run (run),
      .d   (wr_plan_live),
      .q   (wr_plan_q)
   );

   conf_shadow #(.payload_t(stage_vec_t), .DEPTH(1)) rd_stage_sh_i (
      .clk (clk),
      .rst (rst),
      .run (run),
      .d   (rd_stage_live),
      .q   (rd_stage_addr)
   );

   conf_shadow #(.payload_t(stage_vec_t), .DEPTH(3)) wr_stage_sh_i (
      .clk (clk),
      .rst (rst),
      .run (run),
      .d   (wr_stage_live),
      .q   (wr_stage_addr)
   );

   // generators load one cycle after the shadows step
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         run_d <= 1'b0;
      end else begin
         run_d <= run;
      end
   end

   addr_gen #(.ADDR_W(xw_types_pkg::PIXEL_ADDR_W)) rd_ag_i (
      .clk  (clk),
      .rst  (rst),
      .run  (run_d),
      .cfg  (rd_ag_q),
      .addr (rd_addr),
      .en   (rd_en),
      .done (rd_done)
   );

   addr_gen #(.ADDR_W(xw_types_pkg::PIXEL_ADDR_W)) wr_ag_i (
      .clk  (clk),
      .rst  (rst),
      .run  (run_d),
      .cfg  (wr_plan_q.ag),
      .addr (wr_addr),
      .en   (wr_en),
      .done (wr_done)
   );

   dma_len_ctrl dma_len_i (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .dma_ready  (dma_ready),
      .rd_len     (cfg_bus.rd_len),
      .dma_rd_len (dma_rd_len)
   );

   assign dma_wr_len = wr_plan_q.len;
   assign done       = rd_done & wr_done;

endmodule

`default_nettype wire

// ==== dv/tb_layer_write_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_layer_write_ctrl;

   localparam int N_STAGES = 4;
   localparam int PW       = xw_types_pkg::PIXEL_ADDR_W;
   localparam int AW       = xw_types_pkg::IO_ADDR_W;
   localparam int LIMIT    = 500;

   logic                                 clk;
   logic                                 rst;
   logic                                 clear;
   logic                                 run;
   logic                                 valid;
   logic [xw_types_pkg::CFG_ADDR_W-1:0]  addr;
   logic [AW-1:0]                        wdata;
   logic                                 wstrb;
   logic                                 dma_ready;
   logic                                 done;
   logic [PW-1:0]                        rd_addr;
   logic                                 rd_en;
   logic [PW-1:0]                        wr_addr;
   logic                                 wr_en;
   logic [N_STAGES-1:0][AW-1:0]          rd_stage_addr;
   logic [N_STAGES-1:0][AW-1:0]          wr_stage_addr;
   logic [xw_types_pkg::AXI_LEN_W-1:0]   dma_rd_len;
   logic [xw_types_pkg::AXI_LEN_W-1:0]   dma_wr_len;

   logic [31:0]   lfsr_state;
   string         test_name;
   int            errors = 0;
   int            errors_at_open;
   int            tests_run = 0;
   int            tests_failed = 0;
   bit            timed_out = 0;
   int            wr_lead;
   logic [PW-1:0] rd_seen[$];
   logic [PW-1:0] wr_seen[$];
   logic [PW-1:0] exp_addr[$];

   layer_write_ctrl #(.N_STAGES(N_STAGES)) dut_i (
      .clk           (clk),
      .rst           (rst),
      .clear         (clear),
      .run           (run),
      .valid         (valid),
      .addr          (addr),
      .wdata         (wdata),
      .wstrb         (wstrb),
      .dma_ready     (dma_ready),
      .done          (done),
      .rd_addr       (rd_addr),
      .rd_en         (rd_en),
      .wr_addr       (wr_addr),
      .wr_en         (wr_en),
      .rd_stage_addr (rd_stage_addr),
      .wr_stage_addr (wr_stage_addr),
      .dma_rd_len    (dma_rd_len),
      .dma_wr_len    (dma_wr_len)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // shadowed outputs only move on the edge that takes a run
   assert property (@(posedge clk) disable iff (rst)
                    !$past(run) |-> $stable(rd_stage_addr) && $stable(wr_stage_addr)
                                    && $stable(dma_wr_len))
   else begin
      $display("a shadowed output changed without a run pulse at %0t", $time);
      errors++;
   end

   // fibonacci lfsr, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = {lfsr_state[30:0],
                       lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else begin
         $display("ERROR %s %s: expected 0x%0h, actual 0x%0h",
                  test_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic open_test(input string name);
      test_name      = name;
      errors_at_open = errors;
   endtask

   task automatic close_test();
      tests_run++;
      if (errors != errors_at_open) begin
         tests_failed++;
         $display("test %s: failed with %0d errors", test_name, errors - errors_at_open);
      end else begin
         $display("test %s: ok", test_name);
      end
   endtask

   task automatic write_reg(input logic [xw_types_pkg::CFG_ADDR_W-1:0] a,
                            input logic [31:0] d);
      @(negedge clk);
      valid = 1'b1;
      wstrb = 1'b1;
      addr  = a;
      wdata = d;
      @(negedge clk);
      valid = 1'b0;
      wstrb = 1'b0;
   endtask

   // a run is only legal once the multiplier pipeline has caught up
   task automatic settle();
      repeat (xw_types_pkg::MUL_LAT + 2) @(negedge clk);
   endtask

   // pulse run, then record both generators until done comes back
   task automatic run_layer();
      int  cyc;
      bit  seen_wr;
      cyc     = 0;
      seen_wr = 1'b0;
      wr_lead = 0;
      rd_seen.delete();
      wr_seen.delete();
      @(negedge clk);
      run = 1'b1;
      @(negedge clk);
      run = 1'b0;
      @(negedge clk);
      while (!done && !timed_out) begin
         if (rd_en) begin
            rd_seen.push_back(rd_addr);
         end
         if (wr_en) begin
            wr_seen.push_back(wr_addr);
            seen_wr = 1'b1;
         end else if (!seen_wr) begin
            wr_lead++;
         end
         cyc++;
         if (cyc > LIMIT) begin
            $display("timeout: done stayed low for %0d cycles in test %s", cyc, test_name);
            timed_out = 1'b1;
            errors++;
         end
         @(negedge clk);
      end
   endtask

   task automatic build_expected(input int start, input int iter, input int per,
                                 input int shift, input int incr);
      exp_addr.delete();
      for (int k = 0; k < iter; k++) begin
         for (int p = 0; p < per; p++) begin
            exp_addr.push_back(PW'(start + k * shift + p * incr));
         end
      end
   endtask

   task automatic compare_seq(input string what, input bit use_wr);
      logic [PW-1:0] got[$];
      if (use_wr) begin
         got = wr_seen;
      end else begin
         got = rd_seen;
      end
      check_value({what, " count"}, 32'(exp_addr.size()), 32'(got.size()));
      for (int i = 0; i < exp_addr.size() && i < got.size(); i++) begin
         check_value($sformatf("%s addr %0d", what, i), 32'(exp_addr[i]), 32'(got[i]));
      end
   endtask

   task automatic program_write_layer(input int start, input int iter, input int per,
                                      input int shift, input int incr, input int delay);
      write_reg(xw_regmap_pkg::WR_START, start);
      write_reg(xw_regmap_pkg::WR_ITER, iter);
      write_reg(xw_regmap_pkg::WR_PER, per);
      write_reg(xw_regmap_pkg::WR_SHIFT, shift);
      write_reg(xw_regmap_pkg::WR_INCR, incr);
      write_reg(xw_regmap_pkg::WR_DELAY, delay);
   endtask

   task automatic reset_state();
      open_test("reset_state");
      check_value("done", 32'(1), 32'(done));
      check_value("rd_en", 0, 32'(rd_en));
      check_value("wr_en", 0, 32'(wr_en));
      check_value("rd_addr", 0, 32'(rd_addr));
      check_value("wr_addr", 0, 32'(wr_addr));
      check_value("dma_rd_len", 0, 32'(dma_rd_len));
      check_value("dma_wr_len", 0, 32'(dma_wr_len));
      for (int i = 0; i < N_STAGES; i++) begin
         check_value($sformatf("rd stage %0d", i), 0, rd_stage_addr[i]);
         check_value($sformatf("wr stage %0d", i), 0, wr_stage_addr[i]);
      end
      close_test();
   endtask

   task automatic stage_addresses();
      logic [31:0] rd_base;
      logic [31:0] rd_off;
      logic [31:0] wr_base;
      logic [31:0] wr_off;
      open_test("stage_addresses");
      rd_base = rand_bits(32);
      rd_off  = rand_bits(16);
      wr_base = rand_bits(32);
      wr_off  = rand_bits(16);
      write_reg(xw_regmap_pkg::RD_EXT_ADDR, rd_base);
      write_reg(xw_regmap_pkg::RD_OFFSET, rd_off);
      write_reg(xw_regmap_pkg::WR_EXT_ADDR, wr_base);
      write_reg(xw_regmap_pkg::WR_OFFSET, wr_off);
      settle();
      run_layer();
      for (int i = 0; i < N_STAGES; i++) begin
         check_value($sformatf("rd stage %0d", i), rd_base + 32'(i) * rd_off,
                     rd_stage_addr[i]);
         // write side still two layers behind
         check_value($sformatf("wr stage %0d early", i), 0, wr_stage_addr[i]);
      end
      run_layer();
      run_layer();
      for (int i = 0; i < N_STAGES; i++) begin
         check_value($sformatf("wr stage %0d", i), wr_base + 32'(i) * wr_off,
                     wr_stage_addr[i]);
      end
      close_test();
   endtask

   task automatic read_sequence();
      int start;
      int iter;
      int per;
      int shift;
      int incr;
      open_test("read_sequence");
      start = int'(rand_bits(PW));
      iter  = 1 + int'(rand_bits(2));
      per   = 1 + int'(rand_bits(2));
      shift = int'(rand_bits(PW));
      incr  = int'(rand_bits(PW));
      write_reg(xw_regmap_pkg::RD_START, start);
      write_reg(xw_regmap_pkg::RD_ITER, iter);
      write_reg(xw_regmap_pkg::RD_PER, per);
      write_reg(xw_regmap_pkg::RD_SHIFT, shift);
      write_reg(xw_regmap_pkg::RD_INCR, incr);
      settle();
      run_layer();
      // read settings are still one layer away
      check_value("rd count after first run", 0, 32'(rd_seen.size()));
      run_layer();
      build_expected(start, iter, per, shift, incr);
      compare_seq("read layer", 1'b0);
      @(negedge clk);
      check_value("done after read layer", 32'(1), 32'(done));
      close_test();
   endtask

   task automatic queued_layers();
      int a[6];
      int b[6];
      open_test("queued_layers");
      // start, iterations, period, shift, incr, delay
      for (int i = 0; i < 6; i++) begin
         a[i] = int'(rand_bits(PW));
         b[i] = int'(rand_bits(PW));
      end
      a[1] = 1 + int'(rand_bits(2));
      a[2] = 1 + int'(rand_bits(2));
      a[5] = 1 + int'(rand_bits(3));
      b[1] = 1 + int'(rand_bits(2));
      b[2] = 1 + int'(rand_bits(2));
      b[5] = int'(rand_bits(3));
      program_write_layer(a[0], a[1], a[2], a[3], a[4], a[5]);
      settle();
      run_layer();
      program_write_layer(b[0], b[1], b[2], b[3], b[4], b[5]);
      settle();
      run_layer();
      check_value("wr count before layer a", 0, 32'(wr_seen.size()));
      run_layer();
      build_expected(a[0], a[1], a[2], a[3], a[4]);
      compare_seq("layer a", 1'b1);
      check_value("layer a delay", 32'(a[5]), 32'(wr_lead));
      run_layer();
      build_expected(b[0], b[1], b[2], b[3], b[4]);
      compare_seq("layer b", 1'b1);
      check_value("layer b delay", 32'(b[5]), 32'(wr_lead));
      close_test();
   endtask

   task automatic burst_lengths();
      int rd_len;
      int wr_len;
      int model;
      int n;
      open_test("burst_lengths");
      rd_len = 256 + int'(rand_bits(2));
      wr_len = int'(rand_bits(8) | 32'h1);
      write_reg(xw_regmap_pkg::RD_LEN, rd_len);
      write_reg(xw_regmap_pkg::WR_LEN, wr_len);
      settle();
      run_layer();
      check_value("dma_wr_len early", 0, 32'(dma_wr_len));
      run_layer();
      run_layer();
      check_value("dma_wr_len", 32'(wr_len), 32'(dma_wr_len));
      model = rd_len;
      check_value("dma_rd_len loaded", 32'(model > 255 ? 255 : model), 32'(dma_rd_len));
      // long enough to pass zero and reload
      n = rd_len + 4;
      @(negedge clk);
      dma_ready = 1'b1;
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
         model = (model == 0) ? rd_len : model - 1;
         check_value($sformatf("dma_rd_len step %0d", i), 32'(model > 255 ? 255 : model),
                     32'(dma_rd_len));
      end
      dma_ready = 1'b0;
      close_test();
   endtask

   task automatic clear_config();
      open_test("clear_config");
      @(negedge clk);
      clear = 1'b1;
      @(negedge clk);
      clear = 1'b0;
      settle();
      run_layer();
      run_layer();
      run_layer();
      check_value("rd count after clear", 0, 32'(rd_seen.size()));
      check_value("wr count after clear", 0, 32'(wr_seen.size()));
      @(negedge clk);
      check_value("done", 32'(1), 32'(done));
      check_value("rd_en", 0, 32'(rd_en));
      check_value("wr_en", 0, 32'(wr_en));
      check_value("dma_rd_len", 0, 32'(dma_rd_len));
      check_value("dma_wr_len", 0, 32'(dma_wr_len));
      for (int i = 0; i < N_STAGES; i++) begin
         check_value($sformatf("rd stage %0d", i), 0, rd_stage_addr[i]);
         check_value($sformatf("wr stage %0d", i), 0, wr_stage_addr[i]);
      end
      close_test();
   endtask

   initial begin
      lfsr_state = 32'h6c9be89d;
      rst        = 1'b1;
      clear      = 1'b0;
      run        = 1'b0;
      valid      = 1'b0;
      addr       = '0;
      wdata      = '0;
      wstrb      = 1'b0;
      dma_ready  = 1'b0;
      repeat (2) @(negedge clk);
      rst = 1'b0;
      reset_state();
      stage_addresses();
      read_sequence();
      queued_layers();
      burst_lengths();
      clear_config();
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0 && !timed_out) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
design/xw_types_pkg.sv
design/xw_regmap_pkg.sv
design/cfg_if.sv
design/conf_regs.sv
design/conf_shadow.sv
design/stage_addr_calc.sv
design/addr_gen.sv
design/dma_len_ctrl.sv
design/layer_write_ctrl.sv
dv/tb_layer_write_ctrl.sv

// ==== Makefile ====
TOP := tb_layer_write_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f sources.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
